/* source/trap_params.svh */
/*
  Trap checker parameters
  Widths of the PC and cause code, the number of checked exception kinds,
  the RISC-V cause codes of those kinds and their bit positions in a kind mask
*/

`ifndef TRAP_PARAMS_SVH
`define TRAP_PARAMS_SVH

// Width of a PC or an mepc value
`define TRAP_PC_WIDTH     32
// Number of synchronous exception kinds under check
`define TRAP_NUM_KINDS    5
// Exception code field of mcause, without the interrupt bit
`define TRAP_CODE_WIDTH   6

// Cause codes as written by the CSR block on a cause-save
`define TRAP_CODE_ILLEGAL 6'd2
`define TRAP_CODE_ECALL   6'd11
`define TRAP_CODE_EBRK    6'd3
`define TRAP_CODE_BUS_ERR 6'd48
`define TRAP_CODE_MPU_ERR 6'd1

// Bit position of each kind inside a kind mask
`define TRAP_KIND_ILLEGAL 0
`define TRAP_KIND_ECALL   1
`define TRAP_KIND_EBRK    2
`define TRAP_KIND_BUS_ERR 3
`define TRAP_KIND_MPU_ERR 4

`endif

/* source/trap_pkg.sv */
/*
  Trap checker package
  Vector types for PCs, cause codes and kind masks, and the state
  encoding of the single-step checker
*/

`include "trap_params.svh"

package trap_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  // A program counter or a saved mepc
  typedef logic [`TRAP_PC_WIDTH-1:0] pc_t;

  // Exception code of a cause-save, interrupt bit excluded
  typedef logic [`TRAP_CODE_WIDTH-1:0] cause_code_t;

  // One bit per checked exception kind, see the TRAP_KIND_* positions
  typedef logic [`TRAP_NUM_KINDS-1:0] kind_mask_t;

  //////////////////////////////////////////////////
  // Step checker states
  //////////////////////////////////////////////////

  // RUN waits for a stepped retirement
  // STEPPED has seen one retirement and expects debug mode next
  // IRQ_EXCUSED holds off checking until debug mode after an interrupt
  typedef enum logic [1:0] {
    RUN         = 2'd0,
    STEPPED     = 2'd1,
    IRQ_EXCUSED = 2'd2
  } step_state_e;

endpackage

/* source/trap_rec_if.sv */
/*
  Trap record interface
  Carries the first-occurrence flags and mepc values of both the expected
  side (retirement) and the actual side (cause-save) to the comparator
*/

`timescale 1ns/1ps

`include "trap_params.svh"

interface trap_rec_if;

  // Expected side, taken from retiring instructions
  logic [`TRAP_NUM_KINDS-1:0]                     exp_found;
  logic [`TRAP_NUM_KINDS-1:0][`TRAP_PC_WIDTH-1:0] exp_pc;

  // Actual side, taken from the mepc written on a cause-save
  logic [`TRAP_NUM_KINDS-1:0]                     act_found;
  logic [`TRAP_NUM_KINDS-1:0][`TRAP_PC_WIDTH-1:0] act_pc;

  // Written by the capture bank
  modport capture (output exp_found, output exp_pc, output act_found, output act_pc);

  // Read by the comparator
  modport check (input exp_found, input exp_pc, input act_found, input act_pc);

endinterface

/* source/exc_priority.sv */
/*
  Exception classifier
  Maps a retiring instruction and a CSR cause-save onto one-hot exception
  kinds, applying the trap priority of the core and the suppression rules
  for interrupts, debug requests, NMI and debug mode
*/

`timescale 1ns/1ps

`include "trap_params.svh"

module exc_priority (
  input  logic                    wb_valid_i,
  input  logic                    wb_illegal_i,
  input  logic                    wb_ecall_i,
  input  logic                    wb_ebrk_i,
  input  logic                    wb_bus_err_i,
  input  logic                    wb_mpu_err_i,
  input  logic                    irq_ack_i,
  input  logic                    debug_req_i,
  input  logic                    nmi_i,
  input  logic                    debug_mode_i,
  input  logic                    save_cause_i,
  input  logic                    cause_irq_i,
  input  trap_pkg::cause_code_t   cause_code_i,
  output trap_pkg::kind_mask_t    retire_kind_o,
  output trap_pkg::kind_mask_t    cause_kind_o
);

  //////////////////////////////////////////////////
  // Retirement side
  //////////////////////////////////////////////////

  // Retirement that may trap, ignoring debug mode (used by ebreak)
  logic ret_any_mode;
  // Retirement that may trap outside debug mode (all other kinds)
  logic ret_no_debug;

  // Winner of the priority chain, before the suppression terms
  logic mpu_win;
  logic bus_win;
  logic ill_win;
  logic ecall_win;
  logic ebrk_win;

  // An interrupt being taken, an allowed debug request or an NMI
  // replaces the trap of the instruction in writeback
  assign ret_any_mode = wb_valid_i && !irq_ack_i && !debug_req_i && !nmi_i;
  assign ret_no_debug = ret_any_mode && !debug_mode_i;

  // Fetch faults come first, MPU before bus error
  assign mpu_win   = wb_mpu_err_i;
  assign bus_win   = wb_bus_err_i && !wb_mpu_err_i;
  // Decode faults only count when the fetch itself was clean
  assign ill_win   = wb_illegal_i && !wb_bus_err_i && !wb_mpu_err_i;
  assign ecall_win = wb_ecall_i && !wb_illegal_i && !wb_bus_err_i && !wb_mpu_err_i;
  assign ebrk_win  = wb_ebrk_i && !wb_ecall_i && !wb_illegal_i &&
                     !wb_bus_err_i && !wb_mpu_err_i;

  always_comb begin
    retire_kind_o = '0;
    retire_kind_o[`TRAP_KIND_MPU_ERR] = ret_no_debug && mpu_win;
    retire_kind_o[`TRAP_KIND_BUS_ERR] = ret_no_debug && bus_win;
    retire_kind_o[`TRAP_KIND_ILLEGAL] = ret_no_debug && ill_win;
    retire_kind_o[`TRAP_KIND_ECALL]   = ret_no_debug && ecall_win;
    // An ebreak is recorded in debug mode as well
    retire_kind_o[`TRAP_KIND_EBRK]    = ret_any_mode && ebrk_win;
  end

  //////////////////////////////////////////////////
  // Cause-save side
  //////////////////////////////////////////////////

  // Interrupt causes are of no interest here, and unknown codes map to nothing
  always_comb begin
    cause_kind_o = '0;
    if (save_cause_i && !cause_irq_i) begin
      case (cause_code_i)
        `TRAP_CODE_ILLEGAL: cause_kind_o[`TRAP_KIND_ILLEGAL] = 1'b1;
        `TRAP_CODE_ECALL:   cause_kind_o[`TRAP_KIND_ECALL]   = 1'b1;
        `TRAP_CODE_EBRK:    cause_kind_o[`TRAP_KIND_EBRK]    = 1'b1;
        `TRAP_CODE_BUS_ERR: cause_kind_o[`TRAP_KIND_BUS_ERR] = 1'b1;
        `TRAP_CODE_MPU_ERR: cause_kind_o[`TRAP_KIND_MPU_ERR] = 1'b1;
        default:            cause_kind_o = '0;
      endcase
    end
  end

endmodule

/* source/epc_capture.sv */
/*
  Exception PC capture bank
  Records, per exception kind, the PC of the first retirement that should
  trap and the mepc of the first cause-save. Entries are write-once
  until the next reset
*/

`timescale 1ns/1ps

`include "trap_params.svh"

module epc_capture (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  trap_pkg::kind_mask_t retire_kind_i,
  input  trap_pkg::kind_mask_t cause_kind_i,
  input  trap_pkg::pc_t        wb_pc_i,
  input  trap_pkg::pc_t        mepc_n_i,
  trap_rec_if.capture          rec
);

  // First-occurrence flags of both sides
  trap_pkg::kind_mask_t exp_found_q;
  trap_pkg::kind_mask_t act_found_q;

  // Events that hit a kind still empty on that side
  trap_pkg::kind_mask_t exp_new;
  trap_pkg::kind_mask_t act_new;

  // Captured PCs, valid only where the matching flag is set
  trap_pkg::pc_t [`TRAP_NUM_KINDS-1:0] exp_pc_q;
  trap_pkg::pc_t [`TRAP_NUM_KINDS-1:0] act_pc_q;

  assign exp_new = retire_kind_i & ~exp_found_q;
  assign act_new = cause_kind_i & ~act_found_q;

  //////////////////////////////////////////////////
  // Found flags
  //////////////////////////////////////////////////

  // A flag only ever rises, so later events of a kind leave it alone
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      exp_found_q <= '0;
      act_found_q <= '0;
    end else begin
      exp_found_q <= exp_found_q | exp_new;
      act_found_q <= act_found_q | act_new;
    end
  end

  //////////////////////////////////////////////////
  // PC registers
  //////////////////////////////////////////////////

  // Loaded together with the flag, then frozen
  always_ff @(posedge clk) begin
    for (int k = 0; k < `TRAP_NUM_KINDS; k++) begin
      if (exp_new[k]) begin
        exp_pc_q[k] <= wb_pc_i;
      end
      if (act_new[k]) begin
        act_pc_q[k] <= mepc_n_i;
      end
    end
  end

  // Hand the record over to the comparator
  assign rec.exp_found = exp_found_q;
  assign rec.exp_pc    = exp_pc_q;
  assign rec.act_found = act_found_q;
  assign rec.act_pc    = act_pc_q;

endmodule

/* source/epc_compare.sv */
/*
  Exception PC comparator
  Once both the expected and the actual mepc of a kind are recorded,
  compares them a single time and keeps the checked and mismatch flags
*/

`timescale 1ns/1ps

`include "trap_params.svh"

module epc_compare (
  input  logic                 clk,
  input  logic                 rst_ni,
  trap_rec_if.check            rec,
  output trap_pkg::kind_mask_t checked_o,
  output trap_pkg::kind_mask_t mismatch_o
);

  // Kinds with both sides present
  trap_pkg::kind_mask_t both_found;
  // Per kind inequality of the two recorded PCs
  trap_pkg::kind_mask_t pc_differ;

  trap_pkg::kind_mask_t checked_q;
  trap_pkg::kind_mask_t mismatch_q;

  assign both_found = rec.exp_found & rec.act_found;

  always_comb begin
    for (int k = 0; k < `TRAP_NUM_KINDS; k++) begin
      pc_differ[k] = (rec.exp_pc[k] != rec.act_pc[k]);
    end
  end

  // The result is taken in the first cycle both flags are up and never revisited
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      checked_q  <= '0;
      mismatch_q <= '0;
    end else begin
      for (int k = 0; k < `TRAP_NUM_KINDS; k++) begin
        if (both_found[k] && !checked_q[k]) begin
          checked_q[k]  <= 1'b1;
          mismatch_q[k] <= pc_differ[k];
        end
      end
    end
  end

  assign checked_o  = checked_q;
  assign mismatch_o = mismatch_q;

endmodule

/* source/step_checker.sv */
/*
  Single-step checker
  With the step bit set outside debug mode, only one instruction may
  retire before debug mode is entered. An acknowledged interrupt excuses
  the sequence until the next entry into debug mode
*/

`timescale 1ns/1ps

module step_checker (
  input  logic clk,
  input  logic rst_ni,
  input  logic wb_valid_i,
  input  logic step_i,
  input  logic debug_mode_i,
  input  logic irq_ack_i,
  output logic step_violation_o
);

  trap_pkg::step_state_e state_q;
  trap_pkg::step_state_e state_d;

  // Second retirement of a step before the core halts
  logic extra_retire;
  logic violation_q;

  //////////////////////////////////////////////////
  // Next-state logic
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    // The interrupt handler's first instruction may retire, so stop checking
    if (irq_ack_i) begin
      state_d = trap_pkg::IRQ_EXCUSED;
    end else begin
      case (state_q)
        trap_pkg::RUN: begin
          if (wb_valid_i && step_i && !debug_mode_i) begin
            state_d = trap_pkg::STEPPED;
          end
        end
        // Entering debug mode closes the step in either case
        trap_pkg::STEPPED: begin
          if (debug_mode_i) begin
            state_d = trap_pkg::RUN;
          end
        end
        trap_pkg::IRQ_EXCUSED: begin
          if (debug_mode_i) begin
            state_d = trap_pkg::RUN;
          end
        end
        default: state_d = trap_pkg::RUN;
      endcase
    end
  end

  assign extra_retire = (state_q == trap_pkg::STEPPED) && wb_valid_i &&
                        !debug_mode_i && !irq_ack_i;

  //////////////////////////////////////////////////
  // State and sticky flag
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= trap_pkg::RUN;
      violation_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (extra_retire) begin
        violation_q <= 1'b1;
      end
    end
  end

  assign step_violation_o = violation_q;

endmodule

/* source/trap_checker.sv */
/*
  Trap-recording checker, top level
  Watches writeback retirements and CSR cause-saves, checks the saved mepc
  of each exception kind against the trapping PC, and checks single-step
  retirement
*/

`timescale 1ns/1ps

module trap_checker (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  wb_valid_i,
  input  logic                  wb_illegal_i,
  input  logic                  wb_ecall_i,
  input  logic                  wb_ebrk_i,
  input  logic                  wb_bus_err_i,
  input  logic                  wb_mpu_err_i,
  input  trap_pkg::pc_t         wb_pc_i,
  input  logic                  irq_ack_i,
  input  logic                  debug_req_i,
  input  logic                  nmi_i,
  input  logic                  debug_mode_i,
  input  logic                  save_cause_i,
  input  logic                  cause_irq_i,
  input  trap_pkg::cause_code_t cause_code_i,
  input  trap_pkg::pc_t         mepc_n_i,
  input  logic                  step_i,
  output trap_pkg::kind_mask_t  checked_o,
  output trap_pkg::kind_mask_t  mismatch_o,
  output logic                  step_violation_o
);

  // One-hot kinds of the current cycle
  trap_pkg::kind_mask_t retire_kind;
  trap_pkg::kind_mask_t cause_kind;

  // Captured records travel from the capture bank to the comparator
  trap_rec_if rec_if ();

  exc_priority exc_priority_i (
    .wb_valid_i    (wb_valid_i),
    .wb_illegal_i  (wb_illegal_i),
    .wb_ecall_i    (wb_ecall_i),
    .wb_ebrk_i     (wb_ebrk_i),
    .wb_bus_err_i  (wb_bus_err_i),
    .wb_mpu_err_i  (wb_mpu_err_i),
    .irq_ack_i     (irq_ack_i),
    .debug_req_i   (debug_req_i),
    .nmi_i         (nmi_i),
    .debug_mode_i  (debug_mode_i),
    .save_cause_i  (save_cause_i),
    .cause_irq_i   (cause_irq_i),
    .cause_code_i  (cause_code_i),
    .retire_kind_o (retire_kind),
    .cause_kind_o  (cause_kind)
  );

  epc_capture epc_capture_i (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .retire_kind_i (retire_kind),
    .cause_kind_i  (cause_kind),
    .wb_pc_i       (wb_pc_i),
    .mepc_n_i      (mepc_n_i),
    .rec           (rec_if.capture)
  );

  epc_compare epc_compare_i (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .rec        (rec_if.check),
    .checked_o  (checked_o),
    .mismatch_o (mismatch_o)
  );

  // Stepping is judged on raw retirements, trapping or not
  step_checker step_checker_i (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .wb_valid_i       (wb_valid_i),
    .step_i           (step_i),
    .debug_mode_i     (debug_mode_i),
    .irq_ack_i        (irq_ack_i),
    .step_violation_o (step_violation_o)
  );

endmodule

/* sim/tb_clock.sv */
/*
  Testbench clock and reset
  Free-running clock with a 100 ns period, and an active-low reset held
  for two clock cycles and released on a falling edge
*/

`timescale 1ns/1ps

module tb_clock #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge so the first stimulus line sees a clean start
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* sim/trap_checker_assertions.sv */
/*
  Trap checker assertions
  Bound into the top level; checks the one-hot classifier outputs, the
  write-once found flags and PCs, and the comparator's dependence on them
*/

`timescale 1ns/1ps

`include "trap_params.svh"

module trap_checker_assertions (
  input logic                                clk,
  input logic                                rst_ni,
  input trap_pkg::kind_mask_t                retire_kind_i,
  input trap_pkg::kind_mask_t                cause_kind_i,
  input trap_pkg::kind_mask_t                exp_found_i,
  input trap_pkg::kind_mask_t                act_found_i,
  input trap_pkg::pc_t [`TRAP_NUM_KINDS-1:0] exp_pc_i,
  input trap_pkg::pc_t [`TRAP_NUM_KINDS-1:0] act_pc_i,
  input trap_pkg::kind_mask_t                checked_i
);

  // Number of failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  //////////////////////////////////////////////////
  // Classifier
  //////////////////////////////////////////////////

  retire_onehot: assert property (@(posedge clk) disable iff (!rst_ni)
    $onehot0(retire_kind_i))
    else begin
      fail_count++;
      $error("retire kind 0x%h has more than one bit set", retire_kind_i);
    end

  cause_onehot: assert property (@(posedge clk) disable iff (!rst_ni)
    $onehot0(cause_kind_i))
    else begin
      fail_count++;
      $error("cause kind 0x%h has more than one bit set", cause_kind_i);
    end

  //////////////////////////////////////////////////
  // Capture bank and comparator
  //////////////////////////////////////////////////

  // Every flag set in the previous cycle is still set
  found_sticky: assert property (@(posedge clk) disable iff (!rst_ni)
    ((exp_found_i & $past(exp_found_i)) == $past(exp_found_i)) &&
    ((act_found_i & $past(act_found_i)) == $past(act_found_i)))
    else begin
      fail_count++;
      $error("a found flag fell: exp 0x%h act 0x%h", exp_found_i, act_found_i);
    end

  // A recorded PC stays frozen once its flag is up, whatever later events bring
  for (genvar k = 0; k < `TRAP_NUM_KINDS; k++) begin : g_pc_frozen
    pc_frozen: assert property (@(posedge clk) disable iff (!rst_ni)
      (!$past(exp_found_i[k]) || $stable(exp_pc_i[k])) &&
      (!$past(act_found_i[k]) || $stable(act_pc_i[k])))
      else begin
        fail_count++;
        $error("recorded PC of kind %0d changed: exp 0x%h act 0x%h", k,
               exp_pc_i[k], act_pc_i[k]);
      end
  end

  checked_needs_both: assert property (@(posedge clk) disable iff (!rst_ni)
    (checked_i & ~(exp_found_i & act_found_i)) == '0)
    else begin
      fail_count++;
      $error("checked 0x%h without both sides found", checked_i);
    end

endmodule

/* sim/trap_checker_tb.sv */
/*
  Trap checker testbench
  Reads one stimulus line per cycle from the input file, drives the DUT on
  falling edges and compares the sticky result flags with the expected
  columns of the previous line
*/

`timescale 1ns/1ps

`include "trap_params.svh"

module trap_checker_tb;

  localparam int MAX_LINES = 64;
  localparam int NUM_COLS  = 19;

  logic clk;
  logic rst_ni;

  // DUT inputs
  logic wb_valid, wb_illegal, wb_ecall, wb_ebrk, wb_bus_err, wb_mpu_err;
  logic irq_ack, debug_req, nmi, debug_mode, save_cause, cause_irq, step;
  trap_pkg::pc_t         wb_pc;
  trap_pkg::pc_t         mepc_n;
  trap_pkg::cause_code_t cause_code;

  // DUT outputs
  trap_pkg::kind_mask_t checked_o;
  trap_pkg::kind_mask_t mismatch_o;
  logic                 step_violation_o;

  // Parsed stimulus, one row per cycle, and its line in the file
  logic [31:0] fields [0:MAX_LINES-1][0:NUM_COLS-1];
  int          src_line [0:MAX_LINES-1];
  int          num_lines = 0;
  int          cur_line  = 0;

  int cycle_limit = 1000;
  int cycle_count = 0;

  tb_clock clock_i (
    .clk_o  (clk),
    .rst_no (rst_ni)
  );

  trap_checker trap_checker_i (
    .clk (clk), .rst_ni (rst_ni),
    .wb_valid_i (wb_valid), .wb_illegal_i (wb_illegal), .wb_ecall_i (wb_ecall),
    .wb_ebrk_i (wb_ebrk), .wb_bus_err_i (wb_bus_err), .wb_mpu_err_i (wb_mpu_err),
    .wb_pc_i (wb_pc), .irq_ack_i (irq_ack), .debug_req_i (debug_req), .nmi_i (nmi),
    .debug_mode_i (debug_mode), .save_cause_i (save_cause), .cause_irq_i (cause_irq),
    .cause_code_i (cause_code), .mepc_n_i (mepc_n), .step_i (step),
    .checked_o (checked_o), .mismatch_o (mismatch_o),
    .step_violation_o (step_violation_o)
  );

  bind trap_checker trap_checker_assertions assertions_i (
    .clk (clk), .rst_ni (rst_ni),
    .retire_kind_i (retire_kind), .cause_kind_i (cause_kind),
    .exp_found_i (rec_if.exp_found), .act_found_i (rec_if.act_found),
    .exp_pc_i (rec_if.exp_pc), .act_pc_i (rec_if.act_pc),
    .checked_i (checked_o)
  );

  //////////////////////////////////////////////////
  // Result comparison
  //////////////////////////////////////////////////

  task automatic expect_mask(input string name, input trap_pkg::kind_mask_t got,
                             input trap_pkg::kind_mask_t want);
    if (got !== want) begin
      $display("[ERROR] %s = 0x%h, expected 0x%h (input line %0d)", name, got, want, cur_line);
      $display("sim failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic verify_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("[ERROR] %s = 0x%h, expected 0x%h (input line %0d)", name, got, want, cur_line);
      $display("sim failed");
      $fatal(1, "result mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Lines starting with # are comments
  task automatic load_stimulus();
    int          fd;
    int          got;
    int          text_line;
    string       text;
    logic [31:0] col [0:NUM_COLS-1];
    fd = $fopen("sim/trap_checker_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file sim/trap_checker_input.txt");
      $display("sim failed");
      $fatal(1, "no stimulus");
    end
    text_line = 0;
    while ($fgets(text, fd) != 0) begin
      text_line++;
      if (text.len() > 1 && text[0] != "#") begin
        got = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                      col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                      col[15], col[16], col[17], col[18]);
        if (got != NUM_COLS || num_lines == MAX_LINES) begin
          $display("stimulus line %0d is malformed or beyond the table size", text_line);
          $display("sim failed");
          $fatal(1, "bad stimulus");
        end
        for (int k = 0; k < NUM_COLS; k++) begin
          fields[num_lines][k] = col[k];
        end
        src_line[num_lines] = text_line;
        num_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_line(input int n);
    wb_valid   = fields[n][0][0];
    wb_illegal = fields[n][1][0];
    wb_ecall   = fields[n][2][0];
    wb_ebrk    = fields[n][3][0];
    wb_bus_err = fields[n][4][0];
    wb_mpu_err = fields[n][5][0];
    wb_pc      = fields[n][6];
    irq_ack    = fields[n][7][0];
    debug_req  = fields[n][8][0];
    nmi        = fields[n][9][0];
    debug_mode = fields[n][10][0];
    save_cause = fields[n][11][0];
    cause_irq  = fields[n][12][0];
    cause_code = fields[n][13][`TRAP_CODE_WIDTH-1:0];
    mepc_n     = fields[n][14];
    step       = fields[n][15][0];
  endtask

  // Expected columns hold the outputs after the clock edge of that line
  task automatic check_line(input int n);
    cur_line = src_line[n];
    expect_mask("checked_o", checked_o, fields[n][16][`TRAP_NUM_KINDS-1:0]);
    expect_mask("mismatch_o", mismatch_o, fields[n][17][`TRAP_NUM_KINDS-1:0]);
    verify_flag("step_violation_o", step_violation_o, fields[n][18][0]);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and timeout
  //////////////////////////////////////////////////

  initial begin
    {wb_valid, wb_illegal, wb_ecall, wb_ebrk, wb_bus_err, wb_mpu_err} = '0;
    {irq_ack, debug_req, nmi, debug_mode, save_cause, cause_irq, step} = '0;
    wb_pc      = '0;
    mepc_n     = '0;
    cause_code = '0;
    load_stimulus();
    cycle_limit = num_lines + 20;
    @(posedge rst_ni);
    // Each falling edge first checks the previous line, then drives the next
    for (int i = 0; i <= num_lines; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_line(i - 1);
      end
      if (i < num_lines) begin
        apply_line(i);
      end
    end
    if (trap_checker_i.assertions_i.fail_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("%0d assertion failures", trap_checker_i.assertions_i.fail_count);
      $display("sim failed");
      $fatal(1, "assertions failed");
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

endmodule

/* all.f */
+incdir+source
source/trap_pkg.sv
source/trap_rec_if.sv
source/exc_priority.sv
source/epc_capture.sv
source/epc_compare.sv
source/step_checker.sv
source/trap_checker.sv
sim/tb_clock.sv
sim/trap_checker_assertions.sv
sim/trap_checker_tb.sv

/* Makefile */
# Verilator build and run of the trap checker testbench

VERILATOR ?= verilator
TOP       ?= trap_checker_tb
OBJ_DIR   ?= obj_dir
FLIST     ?= all.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
STIMULUS  ?= sim/trap_checker_input.txt

SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Runs from the project root so the stimulus path resolves
run: $(BIN) $(STIMULUS)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* sim/trap_checker_input.txt */
# valid illegal ecall ebrk bus mpu pc irq_ack dbg_req nmi dbg_mode save cause_irq code mepc step
# then checked mismatch step_violation expected after the line's clock edge, all hex
0 0 0 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0 00 00 0
# MPU wins over illegal, an interrupt cause-save is ignored
1 1 0 0 0 1 00003000 0 0 0 0 0 0 00 00000000 0 00 00 0
0 0 0 0 0 0 00000000 0 0 0 0 1 0 01 00003000 0 00 00 0
0 0 0 0 0 0 00000000 0 0 0 0 1 1 02 00003000 0 10 00 0
# Illegal instruction with a matching mepc
1 1 0 0 0 0 00001000 0 0 0 0 0 0 00 00000000 0 10 00 0
0 0 0 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0 10 00 0
0 0 0 0 0 0 00000000 0 0 0 0 1 0 02 00001000 0 10 00 0
0 0 0 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0 11 00 0
# Ecall with a wrong mepc
1 0 1 0 0 0 00002000 0 0 0 0 0 0 00 00000000 0 11 00 0
0 0 0 0 0 0 00000000 0 0 0 0 1 0 0b 00002004 0 11 00 0
0 0 0 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0 13 02 0
0 0 0 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0 13 02 0
# Ebreak during interrupt acknowledge is ignored
1 0 0 1 0 0 00004444 1 0 0 0 0 0 00 00000000 0 13 02 0
1 0 0 1 0 0 00004000 0 0 0 0 0 0 00 00000000 0 13 02 0
0 0 0 0 0 0 00000000 0 0 0 0 1 0 03 00004000 0 13 02 0
0 0 0 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0 17 02 0
# Bus error, the second pair is ignored
1 0 0 0 1 0 00005000 0 0 0 0 0 0 00 00000000 0 17 02 0
0 0 0 0 0 0 00000000 0 0 0 0 1 0 30 00005000 0 17 02 0
1 0 0 0 1 0 00005100 0 0 0 0 0 0 00 00000000 0 1f 02 0
0 0 0 0 0 0 00000000 0 0 0 0 1 0 30 00005200 0 1f 02 0
0 0 0 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0 1f 02 0
# Single step, excused by an interrupt, then a real violation
0 0 0 0 0 0 00000000 0 0 0 1 0 0 00 00000000 0 1f 02 0
1 0 0 0 0 0 00006000 0 0 0 0 0 0 00 00000000 1 1f 02 0
0 0 0 0 0 0 00000000 1 0 0 0 0 0 00 00000000 1 1f 02 0
1 0 0 0 0 0 00006004 0 0 0 0 0 0 00 00000000 1 1f 02 0
0 0 0 0 0 0 00000000 0 0 0 1 0 0 00 00000000 1 1f 02 0
1 0 0 0 0 0 00006008 0 0 0 0 0 0 00 00000000 1 1f 02 0
1 0 0 0 0 0 0000600c 0 0 0 0 0 0 00 00000000 1 1f 02 1
0 0 0 0 0 0 00000000 0 0 0 0 0 0 00 00000000 1 1f 02 1
